// ==== bench/snake_game_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module snake_game_tb;

    localparam int TIMEOUT_CYCLES = 20000;
    localparam int SEED = 53;

    logic clk;
    logic reset;
    logic awvalid;
    logic awready;
    snake_regs_pkg::axil_addr_t awaddr;
    logic wvalid;
    logic wready;
    snake_regs_pkg::axil_data_t wdata;
    logic bvalid;
    logic bready;
    logic [1:0] bresp;
    logic arvalid;
    logic arready;
    snake_regs_pkg::axil_addr_t araddr;
    logic rvalid;
    logic rready;
    snake_regs_pkg::axil_data_t rdata;
    logic [1:0] rresp;

    int cycles = 0;
    int mismatches = 0;
    int proto_errors = 0;

    // Reference model of the game
    snake_pkg::coord_t mx [snake_pkg::MAX_LEN];
    snake_pkg::coord_t my [snake_pkg::MAX_LEN];
    int mlen;
    snake_pkg::score_t mscore;
    logic mover;
    snake_pkg::dir_t mdir;
    snake_pkg::coord_t mfx;
    snake_pkg::coord_t mfy;

    snake_game dut_i (
        .clk(clk), .reset(reset),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("errors: %0d mismatches, %0d protocol errors", mismatches, proto_errors);
            $display("Some tests failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // AXI4-Lite host
    ////////////////////////////////////////////////////////////////////////////

    task automatic write_reg(input snake_regs_pkg::axil_addr_t addr,
                             input snake_regs_pkg::axil_data_t data);
        @(negedge clk);
        awaddr = addr;
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        #1;
        while (!awready) begin
            @(negedge clk);
            #1;
        end
        assert (wready) else begin
            $display("awready rose without wready at address %h", addr);
            proto_errors++;
        end
        @(posedge clk);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid = 1'b0;
        // Response due exactly one cycle after acceptance
        assert (bvalid && bresp == 2'b00) else begin
            $display("write response missing one cycle after acceptance at %h", addr);
            proto_errors++;
        end
    endtask

    // Starts the read on the current falling edge
    task automatic issue_read(input snake_regs_pkg::axil_addr_t addr,
                              output snake_regs_pkg::axil_data_t data);
        araddr = addr;
        arvalid = 1'b1;
        #1;
        while (!arready) begin
            @(negedge clk);
            #1;
        end
        @(posedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        assert (rvalid && rresp == 2'b00) else begin
            $display("read data missing one cycle after acceptance at %h", addr);
            proto_errors++;
        end
        data = rdata;
    endtask

    task automatic read_reg(input snake_regs_pkg::axil_addr_t addr,
                            output snake_regs_pkg::axil_data_t data);
        @(negedge clk);
        issue_read(addr, data);
    endtask

    task automatic compare_word(input string name, input string what,
                                input snake_regs_pkg::axil_data_t expected,
                                input snake_regs_pkg::axil_data_t actual);
        assert (actual == expected) else begin
            $display("mismatch %s %s: expected %h, actual %h", name, what, expected, actual);
            mismatches++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Game model
    ////////////////////////////////////////////////////////////////////////////

    function automatic void reset_model();
        mlen = 1;
        mx[0] = snake_pkg::START_X;
        my[0] = snake_pkg::START_Y;
        mscore = '0;
        mover = 1'b0;
    endfunction

    // Down and left wrap to 511 below zero
    function automatic void next_cell(input snake_pkg::dir_t d,
                                      output snake_pkg::coord_t nx,
                                      output snake_pkg::coord_t ny);
        nx = mx[0];
        ny = my[0];
        case (d)
            2'd0: nx = mx[0] + 9'd1;
            2'd1: ny = my[0] - 9'd1;
            2'd2: nx = mx[0] - 9'd1;
            default: ny = my[0] + 9'd1;
        endcase
    endfunction

    function automatic void apply_move();
        snake_pkg::coord_t nx;
        snake_pkg::coord_t ny;
        logic eat;
        logic grows;
        logic hit;
        if (mover) begin
            return;
        end
        next_cell(mdir, nx, ny);
        eat = (nx == mfx) && (ny == mfy);
        grows = eat && (mlen < snake_pkg::MAX_LEN);
        hit = (nx > 9'd31) || (ny > 9'd31);
        // Tail is vacated unless the body grows
        for (int i = 0; i < mlen; i++) begin
            if (mx[i] == nx && my[i] == ny && !(i == mlen - 1 && !grows)) begin
                hit = 1'b1;
            end
        end
        if (hit) begin
            mover = 1'b1;
            return;
        end
        for (int i = snake_pkg::MAX_LEN - 1; i > 0; i--) begin
            mx[i] = mx[i-1];
            my[i] = my[i-1];
        end
        mx[0] = nx;
        my[0] = ny;
        if (grows) begin
            mlen++;
        end
        if (eat) begin
            mscore = mscore + 8'd1;
        end
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Game actions
    ////////////////////////////////////////////////////////////////////////////

    task automatic expect_state(input string name);
        snake_regs_pkg::axil_data_t got;
        snake_regs_pkg::axil_data_t exp;
        read_reg(snake_regs_pkg::REG_HEAD, got);
        exp = '0;
        exp[snake_regs_pkg::POS_X_LSB +: snake_pkg::COORD_W] = mx[0];
        exp[snake_regs_pkg::POS_Y_LSB +: snake_pkg::COORD_W] = my[0];
        compare_word(name, "head", exp, got);
        read_reg(snake_regs_pkg::REG_STATUS, got);
        exp = '0;
        exp[snake_regs_pkg::STAT_OVER_BIT] = mover;
        exp[snake_regs_pkg::STAT_LEN_LSB +: snake_pkg::LEN_W] = snake_pkg::len_t'(mlen);
        compare_word(name, "status", exp, got);
        read_reg(snake_regs_pkg::REG_SCORE, got);
        exp = '0;
        exp[snake_pkg::SCORE_W-1:0] = mscore;
        compare_word(name, "score", exp, got);
    endtask

    task automatic aim(input snake_pkg::dir_t d);
        snake_regs_pkg::axil_data_t data;
        data = '0;
        data[snake_pkg::DIR_W-1:0] = d;
        write_reg(snake_regs_pkg::REG_DIR, data);
        mdir = d;
    endtask

    task automatic place_food(input snake_pkg::coord_t x, input snake_pkg::coord_t y);
        snake_regs_pkg::axil_data_t data;
        data = '0;
        data[snake_regs_pkg::POS_X_LSB +: snake_pkg::COORD_W] = x;
        data[snake_regs_pkg::POS_Y_LSB +: snake_pkg::COORD_W] = y;
        write_reg(snake_regs_pkg::REG_FOOD, data);
        mfx = x;
        mfy = y;
    endtask

    task automatic take_step(input string name);
        snake_regs_pkg::axil_data_t data;
        snake_regs_pkg::axil_data_t exp;
        snake_regs_pkg::axil_data_t got;
        data = '0;
        data[snake_regs_pkg::CTRL_STEP_BIT] = 1'b1;
        write_reg(snake_regs_pkg::REG_CTRL, data);
        // Status sampled in the cycle right after acceptance
        issue_read(snake_regs_pkg::REG_STATUS, data);
        exp = '0;
        exp[snake_regs_pkg::STAT_BUSY_BIT] = !mover;
        got = '0;
        got[snake_regs_pkg::STAT_BUSY_BIT] = data[snake_regs_pkg::STAT_BUSY_BIT];
        compare_word(name, "busy", exp, got);
        while (data[snake_regs_pkg::STAT_BUSY_BIT]) begin
            read_reg(snake_regs_pkg::REG_STATUS, data);
        end
        apply_move();
        expect_state(name);
    endtask

    task automatic restart_game(input string name);
        snake_regs_pkg::axil_data_t data;
        data = '0;
        data[snake_regs_pkg::CTRL_RESTART_BIT] = 1'b1;
        write_reg(snake_regs_pkg::REG_CTRL, data);
        reset_model();
        expect_state(name);
    endtask

    // Food on the cell straight ahead and one step onto it
    task automatic grow_ahead(input string name);
        snake_pkg::coord_t fx;
        snake_pkg::coord_t fy;
        next_cell(mdir, fx, fy);
        place_food(fx, fy);
        take_step(name);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        snake_regs_pkg::axil_data_t got;
        snake_pkg::coord_t fx;
        snake_pkg::coord_t fy;
        clk = 1'b0;
        reset = 1'b1;
        awvalid = 1'b0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        bready = 1'b1;
        arvalid = 1'b0;
        araddr = '0;
        rready = 1'b1;
        void'($urandom(SEED));
        reset_model();
        mdir = snake_pkg::DIR_RIGHT;
        mfx = '0;
        mfy = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Reset state and unmapped offsets
        expect_state("reset");
        read_reg(snake_regs_pkg::REG_DIR, got);
        compare_word("reset", "dir", '0, got);
        read_reg(snake_regs_pkg::REG_FOOD, got);
        compare_word("reset", "food", '0, got);
        read_reg(8'h18, got);
        compare_word("reset", "unmapped 0x18", '0, got);
        read_reg(8'hFC, got);
        compare_word("reset", "unmapped 0xfc", '0, got);

        // One step each way
        for (int d = 0; d < 4; d++) begin
            aim(snake_pkg::dir_t'(d));
            take_step("direction");
        end

        // Growth up to a full body and two more meals
        restart_game("growth_restart");
        aim(snake_pkg::DIR_RIGHT);
        repeat (9) grow_ahead("growth");
        aim(snake_pkg::DIR_UP);
        take_step("follow_up");
        take_step("follow_up");
        aim(snake_pkg::DIR_LEFT);
        take_step("follow_left");

        // Walls on the high and the low side
        restart_game("wall_restart");
        place_food(9'd0, 9'd31);
        aim(snake_pkg::DIR_RIGHT);
        for (int i = 0; i < 20 && !mover; i++) begin
            take_step("wall_right");
        end
        take_step("after_over");
        take_step("after_over");
        restart_game("wall_restart");
        aim(snake_pkg::DIR_DOWN);
        for (int i = 0; i < 20 && !mover; i++) begin
            take_step("wall_down");
        end
        restart_game("wall_restart");

        // Tight turn into the body at length 5
        aim(snake_pkg::DIR_RIGHT);
        repeat (4) grow_ahead("self_grow");
        place_food(9'd0, 9'd31);
        aim(snake_pkg::DIR_UP);
        take_step("self_turn");
        aim(snake_pkg::DIR_LEFT);
        take_step("self_turn");
        aim(snake_pkg::DIR_DOWN);
        take_step("self_hit");

        // Head into the moving tail at length 2
        restart_game("tail_restart");
        aim(snake_pkg::DIR_RIGHT);
        grow_ahead("tail_grow");
        place_food(9'd0, 9'd31);
        aim(snake_pkg::DIR_LEFT);
        take_step("tail_follow");

        // Random play near the head
        restart_game("random_restart");
        for (int n = 0; n < 200; n++) begin
            aim(snake_pkg::dir_t'($urandom_range(3, 0)));
            if ($urandom_range(1, 0) == 1) begin
                fx = mx[0] + snake_pkg::coord_t'($urandom_range(4, 0)) - 9'd2;
                fy = my[0] + snake_pkg::coord_t'($urandom_range(4, 0)) - 9'd2;
                place_food(fx, fy);
            end
            take_step("random");
            if (mover) begin
                restart_game("random_restart");
            end
        end

        $display("errors: %0d mismatches, %0d protocol errors", mismatches, proto_errors);
        if (mismatches == 0 && proto_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/snake_pkg.sv
logic/snake_regs_pkg.sv
logic/snake_body.sv
logic/snake_rules.sv
logic/snake_regs.sv
logic/snake_game.sv
bench/snake_game_tb.sv

// ==== logic/snake_body.sv ====
`timescale 1ns/10ps
`default_nettype none

module snake_body (
    input  logic clk,
    input  logic reset,
    input  logic shift,
    input  logic grow,
    input  logic clear,
    input  snake_pkg::coord_t new_x,
    input  snake_pkg::coord_t new_y,
    output snake_pkg::coord_t [snake_pkg::MAX_LEN-1:0] seg_x,
    output snake_pkg::coord_t [snake_pkg::MAX_LEN-1:0] seg_y,
    output snake_pkg::len_t length
);

    // Raw segment slots, slot 0 is the head
    snake_pkg::coord_t pos_x [snake_pkg::MAX_LEN];
    snake_pkg::coord_t pos_y [snake_pkg::MAX_LEN];

    snake_pkg::len_t len_q;
    logic [snake_pkg::MAX_LEN-1:0] live;

    ////////////////////////////////////////////////////////////////////////////
    // Position shift register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            // Only the head matters, the rest is masked off
            pos_x[0] <= snake_pkg::START_X;
            pos_y[0] <= snake_pkg::START_Y;
        end else if (shift) begin
            for (int i = snake_pkg::MAX_LEN - 1; i > 0; i--) begin
                pos_x[i] <= pos_x[i-1];
                pos_y[i] <= pos_y[i-1];
            end
            pos_x[0] <= new_x;
            pos_y[0] <= new_y;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Length counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            len_q <= 4'd1;
        end else if (shift && grow) begin
            // Saturate at a full body
            if (int'(len_q) < snake_pkg::MAX_LEN) begin
                len_q <= len_q + 4'd1;
            end
        end
    end

    // One bit per slot holding a live segment
    always_comb begin
        for (int i = 0; i < snake_pkg::MAX_LEN; i++) begin
            live[i] = (i < int'(len_q));
        end
    end

    // Slots past the tail read as zero
    always_comb begin
        for (int i = 0; i < snake_pkg::MAX_LEN; i++) begin
            if (live[i]) begin
                seg_x[i] = pos_x[i];
                seg_y[i] = pos_y[i];
            end else begin
                seg_x[i] = '0;
                seg_y[i] = '0;
            end
        end
    end

    assign length = len_q;

endmodule

`default_nettype wire

// ==== logic/snake_game.sv ====
`timescale 1ns/10ps
`default_nettype none

module snake_game (
    input  logic clk,
    input  logic reset,
    // AXI4-Lite write
    input  logic awvalid,
    output logic awready,
    input  snake_regs_pkg::axil_addr_t awaddr,
    input  logic wvalid,
    output logic wready,
    input  snake_regs_pkg::axil_data_t wdata,
    output logic bvalid,
    input  logic bready,
    output logic [1:0] bresp,
    // AXI4-Lite read
    input  logic arvalid,
    output logic arready,
    input  snake_regs_pkg::axil_addr_t araddr,
    output logic rvalid,
    input  logic rready,
    output snake_regs_pkg::axil_data_t rdata,
    output logic [1:0] rresp
);

    // Host commands into the move controller
    logic step_req;
    logic restart_req;
    snake_pkg::dir_t dir;
    snake_pkg::coord_t food_x;
    snake_pkg::coord_t food_y;

    // Move controller to body
    logic shift;
    logic grow;
    logic clear;
    snake_pkg::coord_t new_x;
    snake_pkg::coord_t new_y;

    // Game status
    logic busy;
    logic over;
    snake_pkg::score_t score;
    snake_pkg::coord_t [snake_pkg::MAX_LEN-1:0] seg_x;
    snake_pkg::coord_t [snake_pkg::MAX_LEN-1:0] seg_y;
    snake_pkg::len_t length;

    snake_regs regs_i (
        .clk(clk), .reset(reset),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .busy(busy), .over(over), .length(length),
        .head_x(seg_x[0]), .head_y(seg_y[0]), .score(score),
        .step_req(step_req), .restart_req(restart_req), .dir(dir),
        .food_x(food_x), .food_y(food_y)
    );

    snake_rules rules_i (
        .clk(clk), .reset(reset),
        .step_req(step_req), .restart_req(restart_req), .dir(dir),
        .food_x(food_x), .food_y(food_y),
        .seg_x(seg_x), .seg_y(seg_y), .length(length),
        .shift(shift), .grow(grow), .clear(clear),
        .busy(busy), .over(over),
        .new_x(new_x), .new_y(new_y), .score(score)
    );

    snake_body body_i (
        .clk(clk), .reset(reset),
        .shift(shift), .grow(grow), .clear(clear),
        .new_x(new_x), .new_y(new_y),
        .seg_x(seg_x), .seg_y(seg_y), .length(length)
    );

endmodule

`default_nettype wire

// ==== logic/snake_pkg.sv ====
`default_nettype none

package snake_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Field and counter widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int COORD_W = 9;
    localparam int DIR_W   = 2;
    localparam int LEN_W   = 4;
    localparam int SCORE_W = 8;

    typedef logic [COORD_W-1:0] coord_t;
    typedef logic [DIR_W-1:0]   dir_t;
    typedef logic [LEN_W-1:0]   len_t;
    typedef logic [SCORE_W-1:0] score_t;

    ////////////////////////////////////////////////////////////////////////////
    // Game constants
    ////////////////////////////////////////////////////////////////////////////

    // Segment slots in the body
    localparam int MAX_LEN = 8;

    // Last valid cell on either axis
    localparam coord_t GRID_MAX = 9'd31;

    // Head after reset or restart
    localparam coord_t START_X = 9'd16;
    localparam coord_t START_Y = 9'd16;

    // Direction encoding, y grows upward
    localparam dir_t DIR_RIGHT = 2'd0;
    localparam dir_t DIR_DOWN  = 2'd1;
    localparam dir_t DIR_LEFT  = 2'd2;
    localparam dir_t DIR_UP    = 2'd3;

    // Move controller states
    typedef enum logic [1:0] {
        RULES_IDLE,
        RULES_CHECK,
        RULES_OVER
    } rules_state_t;

endpackage

`default_nettype wire

// ==== logic/snake_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module snake_regs (
    input  logic clk,
    input  logic reset,
    // AXI4-Lite write
    input  logic awvalid,
    output logic awready,
    input  snake_regs_pkg::axil_addr_t awaddr,
    input  logic wvalid,
    output logic wready,
    input  snake_regs_pkg::axil_data_t wdata,
    output logic bvalid,
    input  logic bready,
    output logic [1:0] bresp,
    // AXI4-Lite read
    input  logic arvalid,
    output logic arready,
    input  snake_regs_pkg::axil_addr_t araddr,
    output logic rvalid,
    input  logic rready,
    output snake_regs_pkg::axil_data_t rdata,
    output logic [1:0] rresp,
    // Game side
    input  logic busy,
    input  logic over,
    input  snake_pkg::len_t length,
    input  snake_pkg::coord_t head_x,
    input  snake_pkg::coord_t head_y,
    input  snake_pkg::score_t score,
    output logic step_req,
    output logic restart_req,
    output snake_pkg::dir_t dir,
    output snake_pkg::coord_t food_x,
    output snake_pkg::coord_t food_y
);

    logic wr_take;
    logic rd_take;
    logic ctrl_hit;
    snake_regs_pkg::axil_data_t rd_mux;

    ////////////////////////////////////////////////////////////////////////////
    // Write channel
    ////////////////////////////////////////////////////////////////////////////

    // Address and data are taken as a pair
    assign wr_take = awvalid && wvalid && !bvalid;
    assign awready = wr_take;
    assign wready  = wr_take;
    assign bresp   = snake_regs_pkg::RESP_OKAY;

    always_ff @(posedge clk) begin
        if (reset) begin
            bvalid <= 1'b0;
        end else if (wr_take) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    // Command pulses in the acceptance cycle
    assign ctrl_hit    = wr_take && (awaddr == snake_regs_pkg::REG_CTRL);
    assign step_req    = ctrl_hit && wdata[snake_regs_pkg::CTRL_STEP_BIT];
    assign restart_req = ctrl_hit && wdata[snake_regs_pkg::CTRL_RESTART_BIT];

    always_ff @(posedge clk) begin
        if (reset) begin
            dir    <= snake_pkg::DIR_RIGHT;
            food_x <= '0;
            food_y <= '0;
        end else if (wr_take) begin
            if (awaddr == snake_regs_pkg::REG_DIR) begin
                dir <= wdata[snake_pkg::DIR_W-1:0];
            end
            if (awaddr == snake_regs_pkg::REG_FOOD) begin
                food_x <= wdata[snake_regs_pkg::POS_X_LSB +: snake_pkg::COORD_W];
                food_y <= wdata[snake_regs_pkg::POS_Y_LSB +: snake_pkg::COORD_W];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read channel
    ////////////////////////////////////////////////////////////////////////////

    assign arready = !rvalid;
    assign rd_take = arvalid && arready;
    assign rresp   = snake_regs_pkg::RESP_OKAY;

    // Control register and unmapped offsets read zero
    always_comb begin
        rd_mux = '0;
        case (araddr)
            snake_regs_pkg::REG_DIR: begin
                rd_mux[snake_pkg::DIR_W-1:0] = dir;
            end
            snake_regs_pkg::REG_FOOD: begin
                rd_mux[snake_regs_pkg::POS_X_LSB +: snake_pkg::COORD_W] = food_x;
                rd_mux[snake_regs_pkg::POS_Y_LSB +: snake_pkg::COORD_W] = food_y;
            end
            snake_regs_pkg::REG_HEAD: begin
                rd_mux[snake_regs_pkg::POS_X_LSB +: snake_pkg::COORD_W] = head_x;
                rd_mux[snake_regs_pkg::POS_Y_LSB +: snake_pkg::COORD_W] = head_y;
            end
            snake_regs_pkg::REG_STATUS: begin
                rd_mux[snake_regs_pkg::STAT_BUSY_BIT] = busy;
                rd_mux[snake_regs_pkg::STAT_OVER_BIT] = over;
                rd_mux[snake_regs_pkg::STAT_LEN_LSB +: snake_pkg::LEN_W] = length;
            end
            snake_regs_pkg::REG_SCORE: begin
                rd_mux[snake_pkg::SCORE_W-1:0] = score;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid <= 1'b0;
        end else if (rd_take) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // Captured once, held while rvalid waits
    always_ff @(posedge clk) begin
        if (rd_take) begin
            rdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

// ==== logic/snake_regs_pkg.sv ====
`default_nettype none

package snake_regs_pkg;

    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;

    typedef logic [ADDR_W-1:0] axil_addr_t;
    typedef logic [DATA_W-1:0] axil_data_t;

    // Register offsets
    localparam axil_addr_t REG_CTRL   = 8'h00;
    localparam axil_addr_t REG_DIR    = 8'h04;
    localparam axil_addr_t REG_FOOD   = 8'h08;
    localparam axil_addr_t REG_HEAD   = 8'h0C;
    localparam axil_addr_t REG_STATUS = 8'h10;
    localparam axil_addr_t REG_SCORE  = 8'h14;

    // Field positions
    localparam int CTRL_STEP_BIT    = 0;
    localparam int CTRL_RESTART_BIT = 1;
    localparam int POS_X_LSB        = 0;
    localparam int POS_Y_LSB        = 16;
    localparam int STAT_BUSY_BIT    = 0;
    localparam int STAT_OVER_BIT    = 1;
    localparam int STAT_LEN_LSB     = 8;

    localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// ==== logic/snake_rules.sv ====
`timescale 1ns/10ps
`default_nettype none

module snake_rules (
    input  logic clk,
    input  logic reset,
    input  logic step_req,
    input  logic restart_req,
    input  snake_pkg::dir_t dir,
    input  snake_pkg::coord_t food_x,
    input  snake_pkg::coord_t food_y,
    input  snake_pkg::coord_t [snake_pkg::MAX_LEN-1:0] seg_x,
    input  snake_pkg::coord_t [snake_pkg::MAX_LEN-1:0] seg_y,
    input  snake_pkg::len_t length,
    output logic shift,
    output logic grow,
    output logic clear,
    output logic busy,
    output logic over,
    output snake_pkg::coord_t new_x,
    output snake_pkg::coord_t new_y,
    output snake_pkg::score_t score
);

    snake_pkg::rules_state_t state;

    snake_pkg::coord_t step_x;
    snake_pkg::coord_t step_y;
    logic wall_hit;
    logic body_hit;
    logic eat;
    logic grow_ok;
    logic hit;

    ////////////////////////////////////////////////////////////////////////////
    // Next head from current head and direction
    ////////////////////////////////////////////////////////////////////////////

    // Underflow wraps to 511 and lands out of bounds
    always_comb begin
        step_x = seg_x[0];
        step_y = seg_y[0];
        case (dir)
            snake_pkg::DIR_RIGHT: step_x = seg_x[0] + 9'd1;
            snake_pkg::DIR_DOWN:  step_y = seg_y[0] - 9'd1;
            snake_pkg::DIR_LEFT:  step_x = seg_x[0] - 9'd1;
            snake_pkg::DIR_UP:    step_y = seg_y[0] + 9'd1;
            default: ;
        endcase
    end

    // Held for the check cycle and the body write
    always_ff @(posedge clk) begin
        if (state == snake_pkg::RULES_IDLE && step_req) begin
            new_x <= step_x;
            new_y <= step_y;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Move checks
    ////////////////////////////////////////////////////////////////////////////

    assign wall_hit = (new_x > snake_pkg::GRID_MAX) || (new_y > snake_pkg::GRID_MAX);
    assign eat      = (new_x == food_x) && (new_y == food_y);
    assign grow_ok  = eat && (int'(length) < snake_pkg::MAX_LEN);

    // The tail moves away unless the body grows this step
    always_comb begin
        body_hit = 1'b0;
        for (int i = 0; i < snake_pkg::MAX_LEN; i++) begin
            if (i < int'(length) && new_x == seg_x[i] && new_y == seg_y[i]) begin
                if (!(i == int'(length) - 1 && !grow_ok)) begin
                    body_hit = 1'b1;
                end
            end
        end
    end

    assign hit = wall_hit || body_hit;

    ////////////////////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || restart_req) begin
            state <= snake_pkg::RULES_IDLE;
        end else begin
            case (state)
                snake_pkg::RULES_IDLE: begin
                    if (step_req) begin
                        state <= snake_pkg::RULES_CHECK;
                    end
                end
                snake_pkg::RULES_CHECK: begin
                    state <= hit ? snake_pkg::RULES_OVER : snake_pkg::RULES_IDLE;
                end
                default: state <= snake_pkg::RULES_OVER;
            endcase
        end
    end

    // Restart wins over a move in flight
    assign shift = (state == snake_pkg::RULES_CHECK) && !hit && !restart_req;
    assign grow  = shift && grow_ok;
    assign clear = restart_req;
    assign busy  = (state == snake_pkg::RULES_CHECK);
    assign over  = (state == snake_pkg::RULES_OVER);

    // Food counts even when the body is already full
    always_ff @(posedge clk) begin
        if (reset || restart_req) begin
            score <= '0;
        end else if (shift && eat) begin
            score <= score + 8'd1;
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the snake game testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
    --top-module snake_game_tb -o snake_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/snake_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "^All tests passed$" sim.log; then
    exit 0
fi
exit 1
